// ==== Makefile ====
# Verilator build and run for the instruction-fetch path.

VERILATOR  ?= verilator
TOP        ?= fetch_tb
LINT_TOP   ?= fetch_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Testbench failed
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/fetch_tb.sv ====
`default_nettype none

module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;
  import inst_pkg::*;

  localparam int RST_CYCLES = 8;
  // windows for words still in flight after a stop and for the idle check.
  localparam int QUIET    = RD_LATENCY + 8;
  localparam int TAIL_WIN = 3 * QUIET;

  // hand-classified words at indices 0..15.
  // higher indices use the fill pattern.
  localparam int N_PRE = 16;
  localparam logic [DATA_W-1:0] PRE_WORD [N_PRE] = '{
    32'h00000013, 32'h00a12083, 32'h00112023, 32'hfe000ee3,
    32'h0080006f, 32'h000080e7, 32'h002081b3, 32'h123452b7,
    32'h00001317, 32'h00000073, 32'h00004501, 32'h0000000b,
    32'hffffffff, 32'h00000000, 32'h0000100f, 32'h40b50533
  };
  localparam op_class_e PRE_CLASS [N_PRE] = '{
    CLS_OP_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH,
    CLS_JAL, CLS_JALR, CLS_OP, CLS_LUI,
    CLS_AUIPC, CLS_SYSTEM, CLS_ILLEGAL, CLS_ILLEGAL,
    CLS_ILLEGAL, CLS_ILLEGAL, CLS_ILLEGAL, CLS_OP
  };

  // per-test start pc, result count before stop, ready odds in quarters and early stop.
  localparam int N_TESTS = 6;
  localparam logic [ADDR_W-1:0] T_PC [N_TESTS] = '{
    32'h000, 32'h000, 32'h040, 32'h3f8, 32'h028, 32'h100
  };
  localparam int T_COUNT [N_TESTS]      = '{1, 16, 24, 4, 1, 8};
  localparam int T_READY [N_TESTS]      = '{4, 4, 2, 3, 4, 1};
  localparam bit T_STOP_EARLY [N_TESTS] = '{0, 0, 0, 0, 1, 0};
  // a stop leaves one word in flight and one last acceptance.
  localparam int T_TAIL_MAX [N_TESTS]   = '{2, 2, 2, 2, 0, 2};

  logic              clk;
  logic              rst;
  logic              load_en;
  logic [IDX_W-1:0]  load_idx;
  logic [DATA_W-1:0] load_data;
  logic              start;
  logic [ADDR_W-1:0] start_pc;
  logic              stop;
  logic              out_valid;
  logic [ADDR_W-1:0] out_pc;
  logic [DATA_W-1:0] out_inst;
  op_class_e         out_class;
  logic              out_ready = 1'b0;

  integer seed = 32'h00b92cc0;
  int     rnd;
  int     ready_level = 4;
  int     cycles = 0;
  int     cycle_limit;
  int     errors = 0;
  int     tests_ok = 0;
  int     tests_bad = 0;

  fetch_top uut (
    .clk         (clk),
    .rst         (rst),
    .load_en_i   (load_en),
    .load_idx_i  (load_idx),
    .load_data_i (load_data),
    .start_i     (start),
    .start_pc_i  (start_pc),
    .stop_i      (stop),
    .out_valid_o (out_valid),
    .out_pc_o    (out_pc),
    .out_inst_o  (out_inst),
    .out_class_o (out_class),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // consumer ready is high with odds of ready_level in four.
  always @(posedge clk) begin
    rnd = $random(seed);
    out_ready <= ((rnd & 3) < ready_level);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, fetch path stopped delivering", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // fill depends on all eight index bits.
  // low byte 0x13 makes every fill word an op-imm.
  function automatic logic [DATA_W-1:0] preload_word(input int idx);
    logic [7:0] b;
    b = idx[7:0];
    if (idx < N_PRE) begin
      return PRE_WORD[idx];
    end
    return {b, ~b, b ^ 8'h3c, 8'h13};
  endfunction

  function automatic logic [DATA_W-1:0] exp_word(input logic [ADDR_W-1:0] pc);
    logic [ADDR_W-3:0] widx;
    widx = pc[ADDR_W-1:2];
    // beyond the array the bus returns zero.
    if (widx >= (ADDR_W-2)'(MEM_DEPTH)) begin
      return '0;
    end
    return preload_word(int'(widx));
  endfunction

  function automatic op_class_e exp_class(input logic [ADDR_W-1:0] pc);
    logic [ADDR_W-3:0] widx;
    widx = pc[ADDR_W-1:2];
    if (widx >= (ADDR_W-2)'(MEM_DEPTH)) begin
      return CLS_FAULT;
    end else if (widx < (ADDR_W-2)'(N_PRE)) begin
      return PRE_CLASS[int'(widx)];
    end
    return CLS_OP_IMM;
  endfunction

  function automatic int calc_limit();
    int sum;
    int t;
    sum = RST_CYCLES + MEM_DEPTH + 200;
    for (t = 0; t < N_TESTS; t++) begin
      sum += T_COUNT[t] * (RD_LATENCY + 8) + TAIL_WIN + QUIET;
    end
    return sum;
  endfunction

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_class(input string name, input op_class_e got,
                             input op_class_e exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %s (%0d) expected %s (%0d)", $time, name,
               got.name(), got, exp.name(), exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input logic [ADDR_W-1:0] pc);
    check_word("out_pc_o", out_pc, pc);
    check_word("out_inst_o", out_inst, exp_word(pc));
    check_class("out_class_o", out_class, exp_class(pc));
  endtask

  // returns on the edge where a word leaves the output port.
  task automatic wait_transfer();
    @(posedge clk);
    while (!(out_valid && out_ready)) begin
      @(posedge clk);
    end
  endtask

  task automatic run_test(input int t);
    logic [ADDR_W-1:0] pc;
    int n_main;
    int n_tail;
    int err0;
    int c;
    pc = T_PC[t];
    n_main = 0;
    n_tail = 0;
    err0 = errors;
    ready_level <= T_READY[t];
    @(posedge clk);
    start    <= 1'b1;
    start_pc <= T_PC[t];
    @(posedge clk);
    start <= 1'b0;
    // early stop lands on the first acceptance.
    if (T_STOP_EARLY[t]) begin
      stop <= 1'b1;
    end
    @(posedge clk);
    stop <= 1'b0;
    while (n_main < T_COUNT[t]) begin
      wait_transfer();
      check_result(pc);
      pc = pc + ADDR_W'(INST_BYTES);
      n_main++;
    end
    if (!T_STOP_EARLY[t]) begin
      stop <= 1'b1;
    end
    ready_level <= 4;
    // words already requested drain in order.
    for (c = 0; c < TAIL_WIN; c++) begin
      @(posedge clk);
      stop <= 1'b0;
      if (out_valid && out_ready) begin
        check_result(pc);
        pc = pc + ADDR_W'(INST_BYTES);
        n_tail++;
      end
    end
    if (n_tail > T_TAIL_MAX[t]) begin
      errors++;
      $display("test %0d: %0d results after stop, at most %0d allowed", t, n_tail,
               T_TAIL_MAX[t]);
    end
    for (c = 0; c < QUIET; c++) begin
      @(posedge clk);
      check_bit("out_valid_o", out_valid, 1'b0);
    end
    if (errors == err0) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("test %0d start %h: %0d results, %0d after stop, %s", t, T_PC[t], n_main,
             n_tail, (errors == err0) ? "ok" : "FAIL");
  endtask

  initial begin
    int i;
    cycle_limit = calc_limit();
    rst       = 1'b0;
    load_en   = 1'b0;
    load_idx  = '0;
    load_data = '0;
    start     = 1'b0;
    start_pc  = '0;
    stop      = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b1;
    // output stays idle through preload.
    for (i = 0; i < MEM_DEPTH; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_idx  <= IDX_W'(i);
      load_data <= preload_word(i);
      check_bit("out_valid_o", out_valid, 1'b0);
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_bit("out_valid_o", out_valid, 1'b0);
    end
    for (i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors", N_TESTS, tests_ok,
             tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : fetch_tb

`default_nettype wire

// ==== rtl/fetch_pc.sv ====
`default_nettype none

module fetch_pc (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      start_i,
  input  logic [mem_pkg::ADDR_W-1:0] start_pc_i,
  input  logic                      stop_i,

  output logic [mem_pkg::ADDR_W-1:0] ar_addr_o,
  output logic                      ar_valid_o,
  input  logic                      ar_ready_i,

  output logic [mem_pkg::ADDR_W-1:0] req_pc_o
);

  import mem_pkg::*;
  import inst_pkg::*;

  fetch_state_e      state_q;
  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] req_pc_q;
  logic              stop_pend_q;
  logic              accept;
  logic              stop_now;

  // address handshake on this edge.
  assign accept = ar_valid_o && ar_ready_i;

  // stop seen now or earlier, applied at acceptance.
  assign stop_now = stop_pend_q || stop_i;

  assign ar_valid_o = (state_q == FS_FETCH);
  assign ar_addr_o  = pc_q;
  assign req_pc_o   = req_pc_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q     <= FS_IDLE;
      pc_q        <= '0;
      stop_pend_q <= 1'b0;
    end else begin
      case (state_q)
        FS_IDLE: begin
          // a stop while idle has nothing to end.
          stop_pend_q <= 1'b0;
          if (start_i) begin
            pc_q    <= start_pc_i;
            state_q <= FS_FETCH;
          end
        end
        FS_FETCH: begin
          if (accept) begin
            pc_q <= pc_q + ADDR_W'(INST_BYTES);
            if (stop_now) begin
              state_q     <= FS_IDLE;
              stop_pend_q <= 1'b0;
            end
          end else if (stop_i) begin
            // hold the request, drop it after acceptance.
            stop_pend_q <= 1'b1;
          end
        end
        default: begin
          state_q <= FS_IDLE;
        end
      endcase
    end
  end

  // pc of the read in flight, kept until the next acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      req_pc_q <= pc_q;
    end
  end

  // address must not move while the sram is busy.
  a_addr_stable : assert property (
    @(posedge clk) disable iff (!rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
  );

endmodule : fetch_pc

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`default_nettype none

module fetch_top (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       load_en_i,
  input  logic [mem_pkg::IDX_W-1:0]  load_idx_i,
  input  logic [mem_pkg::DATA_W-1:0] load_data_i,

  input  logic                       start_i,
  input  logic [mem_pkg::ADDR_W-1:0] start_pc_i,
  input  logic                       stop_i,

  output logic                       out_valid_o,
  output logic [mem_pkg::ADDR_W-1:0] out_pc_o,
  output logic [mem_pkg::DATA_W-1:0] out_inst_o,
  output inst_pkg::op_class_e        out_class_o,
  input  logic                       out_ready_i
);

  import mem_pkg::*;

  // address channel.
  logic [ADDR_W-1:0] ar_addr;
  logic              ar_valid;
  logic              ar_ready;

  // data channel.
  logic [DATA_W-1:0] r_data;
  resp_e             r_resp;
  logic              r_valid;
  logic              r_ready;

  // pc tag for the word in flight.
  logic [ADDR_W-1:0] req_pc;

  fetch_pc u_fetch_pc (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start_i),
    .start_pc_i (start_pc_i),
    .stop_i     (stop_i),
    .ar_addr_o  (ar_addr),
    .ar_valid_o (ar_valid),
    .ar_ready_i (ar_ready),
    .req_pc_o   (req_pc)
  );

  isram u_isram (
    .clk         (clk),
    .rst         (rst),
    .load_en_i   (load_en_i),
    .load_idx_i  (load_idx_i),
    .load_data_i (load_data_i),
    .ar_addr_i   (ar_addr),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .r_data_o    (r_data),
    .r_resp_o    (r_resp),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready)
  );

  inst_predecode u_predecode (
    .clk         (clk),
    .rst         (rst),
    .r_data_i    (r_data),
    .r_resp_i    (r_resp),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready),
    .req_pc_i    (req_pc),
    .out_valid_o (out_valid_o),
    .out_pc_o    (out_pc_o),
    .out_inst_o  (out_inst_o),
    .out_class_o (out_class_o),
    .out_ready_i (out_ready_i)
  );

endmodule : fetch_top

`default_nettype wire

// ==== rtl/inst_pkg.sv ====
`default_nettype none

package inst_pkg;

  // major opcode sits in bits 6:0.
  localparam int OPC_W = 7;

  // low two bits of every uncompressed instruction.
  localparam logic [1:0] INST_LOW_BITS = 2'b11;

  // pc step between sequential words.
  localparam int INST_BYTES = 4;

  // predecode class width.
  localparam int CLS_W = 4;

  // major opcodes of the base integer set.
  typedef enum logic [OPC_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // predecoder output class.
  // one per opcode, then illegal and fault.
  typedef enum logic [CLS_W-1:0] {
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_OP_IMM,
    CLS_OP,
    CLS_LUI,
    CLS_AUIPC,
    CLS_SYSTEM,
    CLS_ILLEGAL,
    CLS_FAULT
  } op_class_e;

  // pc sequencer states.
  typedef enum logic {
    FS_IDLE,
    FS_FETCH
  } fetch_state_e;

  // sram read channel states.
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

endpackage : inst_pkg

`default_nettype wire

// ==== rtl/inst_predecode.sv ====
`default_nettype none

module inst_predecode (
  input  logic                       clk,
  input  logic                       rst,

  input  logic [mem_pkg::DATA_W-1:0] r_data_i,
  input  mem_pkg::resp_e             r_resp_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,

  input  logic [mem_pkg::ADDR_W-1:0] req_pc_i,

  output logic                       out_valid_o,
  output logic [mem_pkg::ADDR_W-1:0] out_pc_o,
  output logic [mem_pkg::DATA_W-1:0] out_inst_o,
  output inst_pkg::op_class_e        out_class_o,
  input  logic                       out_ready_i
);

  import mem_pkg::*;
  import inst_pkg::*;

  logic              full_q;
  logic [ADDR_W-1:0] pc_q;
  logic [DATA_W-1:0] inst_q;
  op_class_e         cls_q;
  logic              take;

  // opcode to class, fault and bad encodings first.
  function automatic op_class_e classify(
    input logic [DATA_W-1:0] word,
    input resp_e             resp
  );
    op_class_e cls;
    if (resp == RESP_SLVERR) begin
      cls = CLS_FAULT;
    end else if (word[1:0] != INST_LOW_BITS) begin
      // compressed or garbage.
      cls = CLS_ILLEGAL;
    end else begin
      case (opcode_e'(word[OPC_W-1:0]))
        OPC_LOAD:   cls = CLS_LOAD;
        OPC_STORE:  cls = CLS_STORE;
        OPC_BRANCH: cls = CLS_BRANCH;
        OPC_JAL:    cls = CLS_JAL;
        OPC_JALR:   cls = CLS_JALR;
        OPC_OP_IMM: cls = CLS_OP_IMM;
        OPC_OP:     cls = CLS_OP;
        OPC_LUI:    cls = CLS_LUI;
        OPC_AUIPC:  cls = CLS_AUIPC;
        OPC_SYSTEM: cls = CLS_SYSTEM;
        default:    cls = CLS_ILLEGAL;
      endcase
    end
    return cls;
  endfunction

  // room when empty or drained on this edge.
  assign r_ready_o = !full_q || out_ready_i;
  assign take      = r_valid_i && r_ready_o;

  assign out_valid_o = full_q;
  assign out_pc_o    = pc_q;
  assign out_inst_o  = inst_q;
  assign out_class_o = cls_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // entry contents, loaded only on a data transfer.
  always_ff @(posedge clk) begin
    if (take) begin
      pc_q   <= req_pc_i;
      inst_q <= r_data_i;
      cls_q  <= classify(r_data_i, r_resp_i);
    end
  end

  a_out_hold : assert property (
    @(posedge clk) disable iff (!rst)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_pc_o) && $stable(out_inst_o) &&
      $stable(out_class_o)
  );

endmodule : inst_predecode

`default_nettype wire

// ==== rtl/isram.sv ====
`default_nettype none

module isram (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       load_en_i,
  input  logic [mem_pkg::IDX_W-1:0]  load_idx_i,
  input  logic [mem_pkg::DATA_W-1:0] load_data_i,

  input  logic [mem_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,

  output logic [mem_pkg::DATA_W-1:0] r_data_o,
  output mem_pkg::resp_e             r_resp_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i
);

  import mem_pkg::*;
  import inst_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  rd_state_e         state_q;
  rd_state_e         state_d;
  logic [LAT_W-1:0]  cnt_q;
  logic [IDX_W-1:0]  idx_q;
  logic              err_q;
  logic [DATA_W-1:0] r_data_q;
  resp_e             r_resp_q;
  logic [ADDR_W-3:0] word_addr;
  logic              addr_ok;
  logic              accept;
  logic              lat_done;

  // byte lane bits are dropped.
  assign word_addr = ar_addr_i[ADDR_W-1:2];
  assign addr_ok   = (word_addr < (ADDR_W-2)'(MEM_DEPTH));

  assign accept   = ar_valid_i && ar_ready_o;
  assign lat_done = (state_q == RD_WAIT) && (cnt_q == '0);

  // only one read in flight.
  assign ar_ready_o = (state_q == RD_IDLE);
  assign r_valid_o  = (state_q == RD_RESP);
  assign r_data_o   = r_data_q;
  assign r_resp_o   = r_resp_q;

  // preload strobe, one word per cycle.
  always_ff @(posedge clk) begin
    if (load_en_i) begin
      mem[load_idx_i] <= load_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (accept) begin
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (lat_done) begin
          state_d = RD_RESP;
        end
      end
      RD_RESP: begin
        // back-pressure keeps the word on the bus.
        if (r_ready_i) begin
          state_d = RD_IDLE;
        end
      end
      default: begin
        state_d = RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= RD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // count latency-1 down to zero, then one more edge.
      if (accept) begin
        cnt_q <= LAT_W'(RD_LATENCY - 1);
      end else if (state_q == RD_WAIT && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // request latched at acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q <= ar_addr_i[IDX_W+1:2];
      err_q <= !addr_ok;
    end
  end

  // array read on the last wait edge.
  always_ff @(posedge clk) begin
    if (lat_done) begin
      r_data_q <= err_q ? '0 : mem[idx_q];
      r_resp_q <= err_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

  a_rvalid_hold : assert property (
    @(posedge clk) disable iff (!rst)
    r_valid_o && !r_ready_i |=>
      r_valid_o && $stable(r_data_o) && $stable(r_resp_o)
  );

  // a new address is never taken with a word still pending.
  a_no_overlap : assert property (
    @(posedge clk) disable iff (!rst)
    !(ar_ready_o && r_valid_o)
  );

endmodule : isram

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // byte address width of the fetch bus.
  localparam int ADDR_W = 32;

  // one instruction word per beat.
  localparam int DATA_W = 32;

  // sram size in words, 1 KiB total.
  localparam int MEM_DEPTH = 256;

  // word index into the array.
  localparam int IDX_W = 8;

  // cycles from address acceptance to read data valid.
  localparam int RD_LATENCY = 3;

  // width of the latency down-counter.
  localparam int LAT_W = $clog2(RD_LATENCY + 1);

  // read response code, same encoding as an AXI bus.
  // okay for a normal read.
  // slverr for an index outside the array.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

endpackage : mem_pkg

`default_nettype wire

// ==== vlog.f ====
rtl/mem_pkg.sv
rtl/inst_pkg.sv
rtl/fetch_pc.sv
rtl/isram.sv
rtl/inst_predecode.sv
rtl/fetch_top.sv
dv/fetch_tb.sv
